// ==== src/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

   // bus and memory sizes
   localparam int ADDR_WIDTH      = 10;
   localparam int DATA_WIDTH      = 32;
   localparam int STRB_WIDTH      = DATA_WIDTH / 8;
   localparam int WORD_ADDR_WIDTH = 8;
   localparam int TAG_WIDTH       = 8;
   localparam int BODY_WIDTH      = 46;

   // command opcodes
   localparam logic OP_WRITE = 1'b1;
   localparam logic OP_READ  = 1'b0;

   // axi response code, the only one the ram returns
   localparam logic [1:0] RESP_OKAY = 2'b00;

   // master transaction states
   localparam int         M_STATE_WIDTH = 3;
   localparam logic [2:0] M_IDLE   = 3'd0;
   localparam logic [2:0] M_WR_AW  = 3'd1;
   localparam logic [2:0] M_WR_B   = 3'd2;
   localparam logic [2:0] M_RD_AR  = 3'd3;
   localparam logic [2:0] M_RD_R   = 3'd4;
   localparam logic [2:0] M_RESULT = 3'd5;

   // one command body, read as a write or as a read
   typedef union packed {
      struct packed {
         logic [ADDR_WIDTH-1:0] addr;
         logic [STRB_WIDTH-1:0] strb;
         logic [DATA_WIDTH-1:0] data;
      } wr;
      struct packed {
         logic [ADDR_WIDTH-1:0]                       addr;
         logic [TAG_WIDTH-1:0]                        tag;
         logic [BODY_WIDTH-ADDR_WIDTH-TAG_WIDTH-1:0]  pad;
      } rd;
   } cmd_body_u;

   // opcode on top, body below
   typedef struct packed {
      logic      op;
      cmd_body_u body;
   } cmd_word_t;

endpackage

`default_nettype wire

// ==== src/cmd_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_intake (
   input  logic              clk,
   input  logic              rst,
   input  logic              cmd_req,
   input  axil_pkg::cmd_word_t cmd_word,
   input  logic              cmd_ready,
   output logic              cmd_ack,
   output logic              cmd_valid,
   output axil_pkg::cmd_word_t cmd_data
);

   logic take;
   logic accept;

   // master drains the holding register
   assign take = cmd_valid && cmd_ready;

   // new word only in idle phase and with an empty holder
   // a host waiting here sits with req high and ack low
   assign accept = !cmd_ack && cmd_req && !cmd_valid;

   // host phase lives in cmd_ack: low is idle, high is acknowledged
   // cmd_valid doubles as the holder full flag
   always_ff @(posedge clk) begin
      if (rst) begin
         cmd_ack   <= 1'b0;
         cmd_valid <= 1'b0;
      end else begin
         if (take) begin
            cmd_valid <= 1'b0;
         end
         if (accept) begin
            cmd_ack   <= 1'b1;
            cmd_valid <= 1'b1;
         end else if (cmd_ack && !cmd_req) begin
            // host dropped req, close the exchange
            cmd_ack <= 1'b0;
         end
      end
   end

   // holding register
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_data <= cmd_word;
      end
   end

endmodule

`default_nettype wire

// ==== src/axil_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_master (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            cmd_valid,
   input  axil_pkg::cmd_word_t             cmd_data,
   output logic                            cmd_ready,
   output logic [axil_pkg::ADDR_WIDTH-1:0] awaddr,
   output logic [2:0]                      awprot,
   output logic                            awvalid,
   input  logic                            awready,
   output logic [axil_pkg::DATA_WIDTH-1:0] wdata,
   output logic [axil_pkg::STRB_WIDTH-1:0] wstrb,
   output logic                            wvalid,
   input  logic                            wready,
   input  logic [1:0]                      bresp,
   input  logic                            bvalid,
   output logic                            bready,
   output logic [axil_pkg::ADDR_WIDTH-1:0] araddr,
   output logic [2:0]                      arprot,
   output logic                            arvalid,
   input  logic                            arready,
   input  logic [axil_pkg::DATA_WIDTH-1:0] rdata,
   input  logic [1:0]                      rresp,
   input  logic                            rvalid,
   output logic                            rready,
   output logic                            res_valid,
   input  logic                            res_ready,
   output logic [axil_pkg::DATA_WIDTH-1:0] res_data,
   output logic [1:0]                      res_code,
   output logic [axil_pkg::TAG_WIDTH-1:0]  res_tag
);

   logic [axil_pkg::M_STATE_WIDTH-1:0] state;
   logic                               start;
   logic                               wr_done;

   // unprivileged, secure, data access
   assign awprot = 3'b000;
   assign arprot = 3'b000;

   // one transaction at a time
   assign cmd_ready = (state == axil_pkg::M_IDLE);
   assign start     = cmd_ready && cmd_valid;

   // aw and w may finish on different cycles
   assign wr_done = (!awvalid || awready) && (!wvalid || wready);

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= axil_pkg::M_IDLE;
         awvalid   <= 1'b0;
         wvalid    <= 1'b0;
         bready    <= 1'b0;
         arvalid   <= 1'b0;
         rready    <= 1'b0;
         res_valid <= 1'b0;
      end else begin
         case (state)
            axil_pkg::M_IDLE: begin
               if (start) begin
                  case (cmd_data.op)
                     axil_pkg::OP_WRITE: begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= axil_pkg::M_WR_AW;
                     end
                     axil_pkg::OP_READ: begin
                        arvalid <= 1'b1;
                        state   <= axil_pkg::M_RD_AR;
                     end
                  endcase
               end
            end
            axil_pkg::M_WR_AW: begin
               if (awready) begin
                  awvalid <= 1'b0;
               end
               if (wready) begin
                  wvalid <= 1'b0;
               end
               if (wr_done) begin
                  bready <= 1'b1;
                  state  <= axil_pkg::M_WR_B;
               end
            end
            axil_pkg::M_WR_B: begin
               if (bvalid) begin
                  bready    <= 1'b0;
                  res_valid <= 1'b1;
                  state     <= axil_pkg::M_RESULT;
               end
            end
            axil_pkg::M_RD_AR: begin
               if (arready) begin
                  arvalid <= 1'b0;
                  rready  <= 1'b1;
                  state   <= axil_pkg::M_RD_R;
               end
            end
            axil_pkg::M_RD_R: begin
               if (rvalid) begin
                  rready    <= 1'b0;
                  res_valid <= 1'b1;
                  state     <= axil_pkg::M_RESULT;
               end
            end
            axil_pkg::M_RESULT: begin
               // hold the result until the return side takes it
               if (res_ready) begin
                  res_valid <= 1'b0;
                  state     <= axil_pkg::M_IDLE;
               end
            end
            default: begin
               state <= axil_pkg::M_IDLE;
            end
         endcase
      end
   end

   // channel payload and result fields
   always_ff @(posedge clk) begin
      if (start) begin
         awaddr   <= cmd_data.body.wr.addr;
         wdata    <= cmd_data.body.wr.data;
         wstrb    <= cmd_data.body.wr.strb;
         araddr   <= cmd_data.body.rd.addr;
         res_data <= '0;
         // tag echoes for reads only
         res_tag  <= (cmd_data.op == axil_pkg::OP_READ) ? cmd_data.body.rd.tag : '0;
      end
      if (state == axil_pkg::M_WR_B && bvalid) begin
         res_code <= bresp;
      end
      if (state == axil_pkg::M_RD_R && rvalid) begin
         res_data <= rdata;
         res_code <= rresp;
      end
   end

endmodule

`default_nettype wire

// ==== src/axil_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_ram (
   input  logic                                 clk,
   input  logic                                 rst,
   // backdoor
   input  logic [axil_pkg::WORD_ADDR_WIDTH-1:0] dbg_addr,
   output logic [axil_pkg::DATA_WIDTH-1:0]      dbg_data,
   input  logic [axil_pkg::WORD_ADDR_WIDTH-1:0] dbg_wr_addr,
   input  logic [axil_pkg::DATA_WIDTH-1:0]      dbg_wr_data,
   input  logic                                 dbg_wr_en,
   // write channels
   input  logic [axil_pkg::ADDR_WIDTH-1:0]      awaddr,
   input  logic [2:0]                           awprot,
   input  logic                                 awvalid,
   output logic                                 awready,
   input  logic [axil_pkg::DATA_WIDTH-1:0]      wdata,
   input  logic [axil_pkg::STRB_WIDTH-1:0]      wstrb,
   input  logic                                 wvalid,
   output logic                                 wready,
   output logic [1:0]                           bresp,
   output logic                                 bvalid,
   input  logic                                 bready,
   // read channels
   input  logic [axil_pkg::ADDR_WIDTH-1:0]      araddr,
   input  logic [2:0]                           arprot,
   input  logic                                 arvalid,
   output logic                                 arready,
   output logic [axil_pkg::DATA_WIDTH-1:0]      rdata,
   output logic [1:0]                           rresp,
   output logic                                 rvalid,
   input  logic                                 rready
);

   logic [axil_pkg::DATA_WIDTH-1:0]      mem [0:(2**axil_pkg::WORD_ADDR_WIDTH)-1];
   logic [axil_pkg::WORD_ADDR_WIDTH-1:0] wr_idx;
   logic [axil_pkg::WORD_ADDR_WIDTH-1:0] rd_idx;
   logic                                 mem_wr_en;
   logic                                 mem_rd_en;

   // byte address to word index, low two bits dropped
   assign wr_idx = awaddr[axil_pkg::ADDR_WIDTH-1 -: axil_pkg::WORD_ADDR_WIDTH];
   assign rd_idx = araddr[axil_pkg::ADDR_WIDTH-1 -: axil_pkg::WORD_ADDR_WIDTH];

   // no error cases, prot is accepted and ignored
   assign bresp = axil_pkg::RESP_OKAY;
   assign rresp = axil_pkg::RESP_OKAY;

   // peek port
   assign dbg_data = mem[dbg_addr];

   // aw and w together, b slot free or draining
   // readies still high means this beat was already taken
   assign mem_wr_en = awvalid && wvalid && (!bvalid || bready) && !awready && !wready;

   // read fires when the r slot is free or draining
   assign mem_rd_en = arvalid && (!rvalid || rready) && !arready;

   // write handshake flops, one-cycle ready pulses
   always_ff @(posedge clk) begin
      if (rst) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         awready <= mem_wr_en;
         wready  <= mem_wr_en;
         // b stays up until the master takes it
         bvalid  <= mem_wr_en || (bvalid && !bready);
      end
   end

   // read handshake flops
   always_ff @(posedge clk) begin
      if (rst) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         arready <= mem_rd_en;
         rvalid  <= mem_rd_en || (rvalid && !rready);
      end
   end

   // registered read data
   always_ff @(posedge clk) begin
      if (mem_rd_en) begin
         rdata <= mem[rd_idx];
      end
   end

   // storage writes
   // bus bytes come last so they override a backdoor poke to the same word
   always_ff @(posedge clk) begin
      if (dbg_wr_en) begin
         mem[dbg_wr_addr] <= dbg_wr_data;
      end
      if (mem_wr_en) begin
         for (int i = 0; i < axil_pkg::STRB_WIDTH; i++) begin
            if (wstrb[i]) begin
               mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/resp_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_return (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            res_valid,
   output logic                            res_ready,
   input  logic [axil_pkg::DATA_WIDTH-1:0] res_data,
   input  logic [1:0]                      res_code,
   input  logic [axil_pkg::TAG_WIDTH-1:0]  res_tag,
   output logic                            rsp_req,
   input  logic                            rsp_ack,
   output logic [axil_pkg::DATA_WIDTH-1:0] rsp_data,
   output logic [1:0]                      rsp_code,
   output logic [axil_pkg::TAG_WIDTH-1:0]  rsp_tag
);

   // holder occupied, from accept until ack falls
   logic busy;
   logic accept;

   // phases: !busy empty, busy with req requesting, busy without req waiting ack low
   assign res_ready = !busy && !rsp_ack;
   assign accept    = res_valid && res_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy    <= 1'b0;
         rsp_req <= 1'b0;
      end else begin
         if (accept) begin
            busy    <= 1'b1;
            rsp_req <= 1'b1;
         end else if (rsp_req && rsp_ack) begin
            rsp_req <= 1'b0;
         end else if (busy && !rsp_req && !rsp_ack) begin
            // all four phases done
            busy <= 1'b0;
         end
      end
   end

   // response register
   always_ff @(posedge clk) begin
      if (accept) begin
         rsp_data <= res_data;
         rsp_code <= res_code;
         rsp_tag  <= res_tag;
      end
   end

endmodule

`default_nettype wire

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
   input  logic                                 clk,
   input  logic                                 rst,
   // host command port
   input  logic                                 cmd_req,
   input  axil_pkg::cmd_word_t                  cmd_word,
   output logic                                 cmd_ack,
   // host response port
   output logic                                 rsp_req,
   input  logic                                 rsp_ack,
   output logic [axil_pkg::DATA_WIDTH-1:0]      rsp_data,
   output logic [1:0]                           rsp_code,
   output logic [axil_pkg::TAG_WIDTH-1:0]       rsp_tag,
   // backdoor
   input  logic [axil_pkg::WORD_ADDR_WIDTH-1:0] dbg_addr,
   output logic [axil_pkg::DATA_WIDTH-1:0]      dbg_data,
   input  logic [axil_pkg::WORD_ADDR_WIDTH-1:0] dbg_wr_addr,
   input  logic [axil_pkg::DATA_WIDTH-1:0]      dbg_wr_data,
   input  logic                                 dbg_wr_en
);

   // intake to master
   logic                cmd_valid;
   logic                cmd_ready;
   axil_pkg::cmd_word_t cmd_data;

   // master to ram
   logic [axil_pkg::ADDR_WIDTH-1:0] awaddr;
   logic [2:0]                      awprot;
   logic                            awvalid;
   logic                            awready;
   logic [axil_pkg::DATA_WIDTH-1:0] wdata;
   logic [axil_pkg::STRB_WIDTH-1:0] wstrb;
   logic                            wvalid;
   logic                            wready;
   logic [1:0]                      bresp;
   logic                            bvalid;
   logic                            bready;
   logic [axil_pkg::ADDR_WIDTH-1:0] araddr;
   logic [2:0]                      arprot;
   logic                            arvalid;
   logic                            arready;
   logic [axil_pkg::DATA_WIDTH-1:0] rdata;
   logic [1:0]                      rresp;
   logic                            rvalid;
   logic                            rready;

   // master to return side
   logic                            res_valid;
   logic                            res_ready;
   logic [axil_pkg::DATA_WIDTH-1:0] res_data;
   logic [1:0]                      res_code;
   logic [axil_pkg::TAG_WIDTH-1:0]  res_tag;

   cmd_intake u_intake (
      .clk       (clk),
      .rst       (rst),
      .cmd_req   (cmd_req),
      .cmd_word  (cmd_word),
      .cmd_ready (cmd_ready),
      .cmd_ack   (cmd_ack),
      .cmd_valid (cmd_valid),
      .cmd_data  (cmd_data)
   );

   axil_master u_master (
      .clk (clk), .rst (rst),
      .cmd_valid (cmd_valid), .cmd_data (cmd_data), .cmd_ready (cmd_ready),
      .awaddr (awaddr), .awprot (awprot), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
      .bresp (bresp), .bvalid (bvalid), .bready (bready),
      .araddr (araddr), .arprot (arprot), .arvalid (arvalid), .arready (arready),
      .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
      .res_valid (res_valid), .res_ready (res_ready),
      .res_data (res_data), .res_code (res_code), .res_tag (res_tag)
   );

   axil_ram u_ram (
      .clk (clk), .rst (rst),
      .dbg_addr (dbg_addr), .dbg_data (dbg_data),
      .dbg_wr_addr (dbg_wr_addr), .dbg_wr_data (dbg_wr_data), .dbg_wr_en (dbg_wr_en),
      .awaddr (awaddr), .awprot (awprot), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
      .bresp (bresp), .bvalid (bvalid), .bready (bready),
      .araddr (araddr), .arprot (arprot), .arvalid (arvalid), .arready (arready),
      .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
   );

   resp_return u_return (
      .clk       (clk),
      .rst       (rst),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_data  (res_data),
      .res_code  (res_code),
      .res_tag   (res_tag),
      .rsp_req   (rsp_req),
      .rsp_ack   (rsp_ack),
      .rsp_data  (rsp_data),
      .rsp_code  (rsp_code),
      .rsp_tag   (rsp_tag)
   );

endmodule

`default_nettype wire

// ==== bench/mem_subsys_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_properties (
   input logic                            clk,
   input logic                            rst,
   input logic                            cmd_req,
   input logic                            cmd_ack,
   input logic                            rsp_req,
   input logic                            rsp_ack,
   input logic [axil_pkg::DATA_WIDTH-1:0] rsp_data,
   input logic                            awvalid,
   input logic                            awready,
   input logic                            arvalid,
   input logic                            arready
);

   // assertion failures so far
   int n_errors = 0;

   // ack stays low while req is low
   ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      !cmd_req && !cmd_ack |=> !cmd_ack)
      else begin
         $error("cmd_ack rose while cmd_req was low");
         n_errors++;
      end

   // response held until the host acknowledges
   rsp_held: assert property (@(posedge clk) disable iff (rst)
      rsp_req && !rsp_ack |=> rsp_req && $stable(rsp_data))
      else begin
         $error("rsp_req dropped or rsp_data changed before rsp_ack");
         n_errors++;
      end

   // axi valids wait for their ready
   aw_held: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid)
      else begin
         $error("awvalid dropped before awready");
         n_errors++;
      end

   ar_held: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid)
      else begin
         $error("arvalid dropped before arready");
         n_errors++;
      end

endmodule

bind mem_subsys_top mem_subsys_properties u_props (
   .clk      (clk),
   .rst      (rst),
   .cmd_req  (cmd_req),
   .cmd_ack  (cmd_ack),
   .rsp_req  (rsp_req),
   .rsp_ack  (rsp_ack),
   .rsp_data (rsp_data),
   .awvalid  (awvalid),
   .awready  (awready),
   .arvalid  (arvalid),
   .arready  (arready)
);

`default_nettype wire

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

   // one table row, data field carries the tag for reads
   typedef struct {
      string                           name;
      logic                            op;
      logic [axil_pkg::ADDR_WIDTH-1:0] addr;
      logic [axil_pkg::STRB_WIDTH-1:0] strb;
      logic [axil_pkg::DATA_WIDTH-1:0] data;
      logic [axil_pkg::DATA_WIDTH-1:0] exp_data;
      logic [1:0]                      exp_code;
      logic [axil_pkg::TAG_WIDTH-1:0]  exp_tag;
   } entry_t;

   logic                clk;
   logic                rst;
   logic                cmd_req;
   axil_pkg::cmd_word_t cmd_word;
   logic                cmd_ack;
   logic                rsp_req;
   logic                rsp_ack;
   logic [31:0]         rsp_data;
   logic [1:0]          rsp_code;
   logic [7:0]          rsp_tag;
   logic [7:0]          dbg_addr;
   logic [31:0]         dbg_data;
   logic [7:0]          dbg_wr_addr;
   logic [31:0]         dbg_wr_data;
   logic                dbg_wr_en;

   entry_t      tbl[$];
   // table indexes in issue order, popped by the response side
   int          sb[$];
   // word indexes touched by bus writes, peeked at the end
   logic [7:0]  written[$];
   logic [31:0] ref_mem [0:255];
   logic [31:0] rng;
   bit          table_ready;
   int          n_pass;
   int          n_fail;

   mem_subsys_top u_dut (
      .clk         (clk),
      .rst         (rst),
      .cmd_req     (cmd_req),
      .cmd_word    (cmd_word),
      .cmd_ack     (cmd_ack),
      .rsp_req     (rsp_req),
      .rsp_ack     (rsp_ack),
      .rsp_data    (rsp_data),
      .rsp_code    (rsp_code),
      .rsp_tag     (rsp_tag),
      .dbg_addr    (dbg_addr),
      .dbg_data    (dbg_data),
      .dbg_wr_addr (dbg_wr_addr),
      .dbg_wr_data (dbg_wr_data),
      .dbg_wr_en   (dbg_wr_en)
   );

   // 100 ns period
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // pack a row into the command union, write or read view
   function automatic axil_pkg::cmd_word_t make_cmd(input entry_t e);
      axil_pkg::cmd_word_t w;
      w = '0;
      w.op = e.op;
      if (e.op == axil_pkg::OP_WRITE) begin
         w.body.wr.addr = e.addr;
         w.body.wr.strb = e.strb;
         w.body.wr.data = e.data;
      end else begin
         w.body.rd.addr = e.addr;
         w.body.rd.tag  = e.data[7:0];
      end
      return w;
   endfunction

   function automatic bit field_matches(input string name, input string field,
                                        input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         $display("FAILED %s %s: expected %h, actual %h", name, field, exp, got);
         return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic finish_test(input string name, input bit ok);
      if (ok) begin
         n_pass++;
      end else begin
         n_fail++;
      end
      $display("test %s %s", name, ok ? "passed" : "failed");
   endtask

   // write row, reference word merged byte by byte
   task automatic add_write(input string name, input logic [9:0] addr,
                            input logic [3:0] strb, input logic [31:0] data);
      entry_t     e;
      logic [7:0] idx;
      idx = addr[9:2];
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            ref_mem[idx][8*b +: 8] = data[8*b +: 8];
         end
      end
      e = '{name, axil_pkg::OP_WRITE, addr, strb, data, 32'h0, axil_pkg::RESP_OKAY, 8'h00};
      tbl.push_back(e);
      written.push_back(idx);
   endtask

   // read row, expects the reference word and the echoed tag
   task automatic add_read(input string name, input logic [9:0] addr, input logic [7:0] tag);
      entry_t e;
      e = '{name, axil_pkg::OP_READ, addr, 4'h0, {24'h0, tag}, ref_mem[addr[9:2]],
            axil_pkg::RESP_OKAY, tag};
      tbl.push_back(e);
   endtask

   task automatic build_table();
      logic [9:0] a;
      // backdoor poke lands before any command
      ref_mem[8'h40] = 32'h5a3c9e17;
      add_write("wr_full", 10'h010, 4'hf, 32'h11223344);
      add_read("rd_full", 10'h010, 8'h3a);
      // low address bits ignored
      add_write("wr_part_lo", 10'h011, 4'b0011, 32'haabbccdd);
      add_write("wr_part_hi", 10'h013, 4'b1000, 32'h99000000);
      add_read("rd_part", 10'h012, 8'h51);
      add_read("rd_poked", 10'h100, 8'hc4);
      add_write("wr_over_poke", 10'h100, 4'b0100, 32'h00ee0000);
      add_read("rd_over_poke", 10'h102, 8'h07);
      // back to back mix, random data
      a = 10'h080;
      for (int k = 0; k < 4; k++) begin
         rng = xorshift32(rng);
         add_write($sformatf("burst_wr_%0d", k), a, 4'hf, rng);
         add_read($sformatf("burst_rd_%0d", k), a, 8'(128 + k));
         a = a + 10'h004;
      end
   endtask

   task automatic send_commands();
      for (int i = 0; i < tbl.size(); i++) begin
         cmd_word = make_cmd(tbl[i]);
         sb.push_back(i);
         cmd_req = 1'b1;
         do begin
            @(posedge clk);
            #1;
         end while (!cmd_ack);
         cmd_req = 1'b0;
         do begin
            @(posedge clk);
            #1;
         end while (cmd_ack);
      end
   endtask

   task automatic collect_responses();
      entry_t     e;
      logic [2:0] delay;
      bit         ok;
      for (int n = 0; n < tbl.size(); n++) begin
         while (!rsp_req) begin
            @(posedge clk);
            #1;
         end
         // random ack delay, 0 to 7 cycles
         rng = xorshift32(rng);
         delay = rng[2:0];
         repeat (delay) begin
            @(posedge clk);
            #1;
         end
         if (sb.size() == 0) begin
            $display("response arrived with no command outstanding");
            n_fail++;
         end else begin
            e = tbl[sb.pop_front()];
            ok = 1'b1;
            ok &= field_matches(e.name, "data", e.exp_data, rsp_data);
            ok &= field_matches(e.name, "code", 32'(e.exp_code), 32'(rsp_code));
            ok &= field_matches(e.name, "tag", 32'(e.exp_tag), 32'(rsp_tag));
            finish_test(e.name, ok);
         end
         rsp_ack = 1'b1;
         while (rsp_req) begin
            @(posedge clk);
            #1;
         end
         rsp_ack = 1'b0;
      end
   endtask

   initial begin
      bit ok;
      cmd_req     = 1'b0;
      cmd_word    = '0;
      rsp_ack     = 1'b0;
      dbg_addr    = 8'h00;
      dbg_wr_addr = 8'h00;
      dbg_wr_data = 32'h0;
      dbg_wr_en   = 1'b0;
      rst         = 1'b1;
      rng         = 32'h0b55895b;
      build_table();
      table_ready = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      // handshake outputs quiet before any command
      ok = field_matches("idle_after_reset", "cmd_ack", 32'd0, 32'(cmd_ack));
      ok &= field_matches("idle_after_reset", "rsp_req", 32'd0, 32'(rsp_req));
      finish_test("idle_after_reset", ok);

      // backdoor poke, one cycle
      dbg_wr_addr = 8'h40;
      dbg_wr_data = 32'h5a3c9e17;
      dbg_wr_en   = 1'b1;
      @(posedge clk);
      #1;
      dbg_wr_en = 1'b0;

      fork
         send_commands();
         collect_responses();
      join

      // nothing duplicated after the last response
      repeat (20) @(posedge clk);
      #1;
      ok = field_matches("no_extra_response", "rsp_req", 32'd0, 32'(rsp_req));
      ok &= field_matches("no_extra_response", "pending", 32'd0, 32'(sb.size()));
      finish_test("no_extra_response", ok);

      // bus writes seen through the peek port
      ok = 1'b1;
      foreach (written[i]) begin
         dbg_addr = written[i];
         #1;
         ok &= field_matches("backdoor_peek", $sformatf("word %h", written[i]),
                             ref_mem[written[i]], dbg_data);
      end
      finish_test("backdoor_peek", ok);

      // handshake and axi hold rules over the whole run
      ok = field_matches("bound_properties", "failures", 32'd0,
                         32'(u_dut.u_props.n_errors));
      finish_test("bound_properties", ok);

      $display("tests: %0d passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // budget of 40 cycles per row plus setup
   initial begin
      wait (table_ready);
      repeat (tbl.size() * 40 + 100) @(posedge clk);
      $display("timeout: the run did not complete within %0d clock periods",
               tbl.size() * 40 + 100);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
src/axil_pkg.sv
src/cmd_intake.sv
src/axil_master.sv
src/axil_ram.sv
src/resp_return.sv
src/mem_subsys_top.sv
bench/mem_subsys_properties.sv
bench/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
